// File: files.f
+incdir+hdl
hdl/standby_pkg.sv
hdl/button_sync.sv
hdl/iprog_sequencer.sv
hdl/icap_port.sv
hdl/standby_top.sv
tb/standby_sva.sv
tb/standby_tb.sv

// File: Bender.yml
package:
  name: standby_reconfig

export_include_dirs:
  - hdl

sources:
  - hdl/standby_pkg.sv
  - hdl/button_sync.sv
  - hdl/iprog_sequencer.sv
  - hdl/icap_port.sv
  - hdl/standby_top.sv
  - target: test
    files:
      - tb/standby_sva.sv
      - tb/standby_tb.sv

// File: tb/standby_tb.sv
// Testbench for the standby controller with LFSR stimulus, port word capture and per-test checks.
`include "standby_macros.svh"

module standby_tb;

	localparam int RESET_CYCLES = 5;
	localparam int TEST_SLOTS = 6;
	localparam int TIMEOUT_CYCLES = TEST_SLOTS * (RESET_CYCLES + 31 + 16) + 50;
	// Port words before bit mirroring, slot 6 holds the boot address.
	localparam logic [15:0] SEQ_WORDS[10] = '{16'hFFFF, 16'hAA99, 16'h5566, 16'h3261,
		16'h0000, 16'h3281, 16'h0000, 16'h30A1, 16'h000E, 16'h2000};

	logic clk;
	logic rst_n;
	logic btn_start;
	logic btn_rescue;
	logic [15:0] icap_data;
	logic icap_ce_n;
	logic icap_write_n;
	logic seq_done;

	int cycle_cnt;
	int errors;
	int tests_run;
	int tests_failed;
	int err_mark;
	int press_edge;   // Edge on which btn_start was driven high.
	logic [31:0] lfsr;
	logic [15:0] cap_words[$];
	int cap_cycles[$];

	standby_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.btn_start    (btn_start),
		.btn_rescue   (btn_rescue),
		.icap_data    (icap_data),
		.icap_ce_n    (icap_ce_n),
		.icap_write_n (icap_write_n),
		.seq_done     (seq_done)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// Every enabled port cycle carries one word.
	always @(negedge clk) begin
		if (rst_n && !icap_ce_n) begin
			cap_words.push_back(icap_data);
			cap_cycles.push_back(cycle_cnt);
		end
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
		$display("** FAIL **");
		$finish;
	end

	// Galois LFSR, one step per bit handed out.
	function automatic int draw_random(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// Each byte goes to the port with its bit order mirrored.
	function automatic logic [15:0] expected_word(input int idx, input logic [15:0] boot_addr);
		logic [15:0] w;
		logic [15:0] r;
		w = (idx == 6) ? boot_addr : SEQ_WORDS[idx];
		for (int j = 0; j < 8; j++) begin
			r[j] = w[7-j];
			r[15-j] = w[8+j];
		end
		return r;
	endfunction

	function automatic int total_errors();
		return errors + dut0.sva0.errors;
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		btn_start <= 1'b0;
		btn_rescue <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic clear_capture();
		cap_words.delete();
		cap_cycles.delete();
	endtask

	task automatic check_quiet(input int n);
		repeat (n) begin
			@(negedge clk);
			assert (icap_ce_n && icap_write_n && !seq_done) else begin
				$display("FAIL %0t: port active or done set while idle", $time);
				errors++;
			end
		end
	endtask

	task automatic press_start();
		@(posedge clk);
		btn_start <= 1'b1;
		press_edge = cycle_cnt + 1;
		repeat (2) @(posedge clk);
		btn_start <= 1'b0;
	endtask

	task automatic wait_done();
		do begin
			@(negedge clk);
		end while (!seq_done);
		@(negedge clk);   // Last word is still on the port when done rises.
	endtask

	task automatic check_sequence(input logic [15:0] boot_addr);
		assert (cap_words.size() == 10) else begin
			$display("FAIL %0t: captured %0d words, expected 10", $time, cap_words.size());
			errors++;
		end
		for (int i = 0; i < 10 && i < cap_words.size(); i++) begin
			assert (cap_words[i] == expected_word(i, boot_addr)) else begin
				$display("FAIL %0t: word %0d is %h, expected %h", $time, i,
					cap_words[i], expected_word(i, boot_addr));
				errors++;
			end
			assert (cap_cycles[i] == press_edge + 4 + i) else begin
				$display("FAIL %0t: word %0d at cycle %0d, expected cycle %0d", $time, i,
					cap_cycles[i], press_edge + 4 + i);
				errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		repeat (2) @(posedge clk);   // Pending assertions settle.
		tests_run++;
		if (total_errors() == err_mark) begin
			$display("Test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", tests_run, name, total_errors() - err_mark);
		end
		err_mark = total_errors();
	endtask

	initial begin
		int gap;
		rst_n = 1'b0;
		btn_start = 1'b0;
		btn_rescue = 1'b0;
		lfsr = 32'h4a9bd07d;

		apply_reset();
		check_quiet(5 + draw_random(5));
		end_test("idle after reset");

		apply_reset();
		check_quiet(draw_random(5));
		clear_capture();
		press_start();
		wait_done();
		check_sequence(`STANDBY_REGULAR_ADDR);
		end_test("regular boot");

		// Rescue held across the start press.
		apply_reset();
		check_quiet(draw_random(5));
		clear_capture();
		@(posedge clk);
		btn_rescue <= 1'b1;
		repeat (3) @(posedge clk);
		press_start();
		repeat (2) @(posedge clk);
		btn_rescue <= 1'b0;
		wait_done();
		check_sequence(`STANDBY_RESCUE_ADDR);
		end_test("rescue boot");

		apply_reset();
		press_start();
		wait_done();
		clear_capture();
		gap = draw_random(5);
		repeat (gap + 4) begin
			@(posedge clk);
			btn_start <= (draw_random(1) == 1);
			btn_rescue <= (draw_random(1) == 1);
			@(negedge clk);
			assert (seq_done && icap_ce_n) else begin
				$display("FAIL %0t: port enabled or done dropped after the sequence", $time);
				errors++;
			end
		end
		assert (cap_words.size() == 0) else begin
			$display("FAIL %0t: %0d words after done, expected 0", $time, cap_words.size());
			errors++;
		end
		end_test("presses after done");

		apply_reset();
		press_start();
		do begin
			@(negedge clk);
		end while (icap_ce_n);
		repeat (draw_random(3)) @(posedge clk);
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		assert (icap_ce_n && icap_write_n && !seq_done) else begin
			$display("FAIL %0t: reset did not quiet the port at once", $time);
			errors++;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		clear_capture();
		check_quiet(draw_random(5));
		press_start();
		wait_done();
		check_sequence(`STANDBY_REGULAR_ADDR);
		end_test("reset mid-sequence");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: tb/standby_sva.sv
// Protocol assertions on the standby controller ports and their bind to the top level.
module standby_sva (
	input logic                    clk,
	input logic                    rst_n,
	input logic [15:0]             icap_data,
	input logic                    icap_ce_n,
	input logic                    icap_write_n,
	input logic                    seq_done,
	input standby_pkg::seq_state_e state
);

	int errors;   // Failure count, read by the testbench.
	standby_pkg::icap_word_u port_word;

	// Undo the per-byte bit mirror of the port.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			port_word.raw[i] = icap_data[7-i];
			port_word.raw[8+i] = icap_data[15-i];
		end
	end

	strobes_match: assert property (@(posedge clk) disable iff (!rst_n)
		icap_ce_n == icap_write_n)
	else begin
		$error("enable and write strobes differ");
		errors++;
	end

	reset_quiet: assert property (@(posedge clk)
		(!rst_n ##1 !rst_n) |-> (icap_ce_n && icap_write_n && !seq_done))
	else begin
		$error("port active or done set during reset");
		errors++;
	end

	first_word_dummy: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(icap_ce_n) |-> (port_word.raw == 16'hFFFF))
	else begin
		$error("first enabled word is not the dummy word");
		errors++;
	end

	type1_opcode: assert property (@(posedge clk) disable iff (!rst_n)
		(!icap_ce_n && port_word.hdr.pkt_type == 3'b001) |->
		(port_word.hdr.opcode inside {standby_pkg::WRITE, standby_pkg::NOP}))
	else begin
		$error("type 1 header with a read or reserved opcode");
		errors++;
	end

	// Done state holds and the port stays deselected.
	quiet_after_done: assert property (@(posedge clk) disable iff (!rst_n)
		(seq_done && state == standby_pkg::DONE) |=> (icap_ce_n && seq_done))
	else begin
		$error("port enabled or done dropped after the sequence finished");
		errors++;
	end

endmodule

bind standby_top standby_sva sva0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.icap_data    (icap_data),
	.icap_ce_n    (icap_ce_n),
	.icap_write_n (icap_write_n),
	.seq_done     (seq_done),
	.state        (seq0.state)
);

// File: hdl/standby_top.sv
// Top level joining the button synchronizers, the IPROG sequencer and the port register.
module standby_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        btn_start,
	input  logic        btn_rescue,
	output logic [15:0] icap_data,
	output logic        icap_ce_n,
	output logic        icap_write_n,
	output logic        seq_done
);

	logic start_sync;
	logic rescue_sync;
	standby_pkg::icap_word_u seq_word;
	logic seq_word_valid;

	// Buttons arrive straight from the board.
	button_sync sync_start (
		.clk      (clk),
		.rst_n    (rst_n),
		.async_in (btn_start),
		.sync_out (start_sync)
	);

	button_sync sync_rescue (
		.clk      (clk),
		.rst_n    (rst_n),
		.async_in (btn_rescue),
		.sync_out (rescue_sync)
	);

	iprog_sequencer seq0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start_sync),
		.rescue_req (rescue_sync),
		.word       (seq_word),
		.word_valid (seq_word_valid),
		.seq_done   (seq_done)
	);

	// One word per cycle, no back-pressure.
	icap_port port0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.word         (seq_word),
		.word_valid   (seq_word_valid),
		.icap_data    (icap_data),
		.icap_ce_n    (icap_ce_n),
		.icap_write_n (icap_write_n)
	);

endmodule

// File: hdl/icap_port.sv
// Port output register with per-byte bit reversal and active-low enable and write strobes.
module icap_port (
	input  logic                    clk,
	input  logic                    rst_n,
	input  standby_pkg::icap_word_u word,
	input  logic                    word_valid,
	output logic [15:0]             icap_data,
	output logic                    icap_ce_n,
	output logic                    icap_write_n
);

	logic [15:0] swapped;

	// The port takes each byte with its bits mirrored, byte order unchanged.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			swapped[i] = word.raw[7-i];
			swapped[8+i] = word.raw[15-i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			icap_data <= 16'h0000;
			icap_ce_n <= 1'b1;      // Port deselected.
			icap_write_n <= 1'b1;
		end else begin
			icap_data <= swapped;
			icap_ce_n <= ~word_valid;
			icap_write_n <= ~word_valid;   // Write only, never read back.
		end
	end

endmodule

// File: hdl/iprog_sequencer.sv
// FSM issuing the IPROG reconfiguration word sequence with rescue or regular boot address.
`include "standby_macros.svh"

module iprog_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    rescue_req,
	output standby_pkg::icap_word_u word,
	output logic                    word_valid,
	output logic                    seq_done
);

	// Packet and register codes of the configuration port.
	localparam logic [2:0] PKT_TYPE1 = 3'b001;
	localparam logic [5:0] REG_CMD = 6'h05;
	localparam logic [5:0] REG_GENERAL1 = 6'h13;
	localparam logic [5:0] REG_GENERAL2 = 6'h14;
	localparam logic [15:0] CMD_IPROG = 16'h000E;

	standby_pkg::seq_state_e state;
	standby_pkg::seq_state_e next_state;
	logic rescue;

	// Builds a type-1 header word from its fields.
	function automatic standby_pkg::icap_word_u type1_hdr(
		input standby_pkg::icap_op_e op,
		input logic [5:0]            addr,
		input logic [4:0]            cnt
	);
		standby_pkg::icap_word_u w;
		w.hdr.pkt_type = PKT_TYPE1;
		w.hdr.opcode = op;
		w.hdr.reg_addr = addr;
		w.hdr.word_cnt = cnt;
		return w;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= standby_pkg::IDLE;
			rescue <= 1'b0;
		end else begin
			state <= next_state;
			// Boot choice is frozen once the sequence leaves idle.
			if (state == standby_pkg::IDLE) begin
				rescue <= rescue_req;
			end
		end
	end

	// Straight chain of states, each emitting one word.
	always_comb begin
		next_state = state;
		unique case (state)
			standby_pkg::IDLE: begin
				if (start) begin
					next_state = standby_pkg::DUMMY;
				end
			end
			standby_pkg::DUMMY:     next_state = standby_pkg::SYNC1;
			standby_pkg::SYNC1:     next_state = standby_pkg::SYNC2;
			standby_pkg::SYNC2:     next_state = standby_pkg::GEN1_HDR;
			standby_pkg::GEN1_HDR:  next_state = standby_pkg::GEN1_DATA;
			standby_pkg::GEN1_DATA: next_state = standby_pkg::GEN2_HDR;
			standby_pkg::GEN2_HDR:  next_state = standby_pkg::GEN2_DATA;
			standby_pkg::GEN2_DATA: next_state = standby_pkg::CMD_HDR;
			standby_pkg::CMD_HDR:   next_state = standby_pkg::IPROG;
			standby_pkg::IPROG:     next_state = standby_pkg::NOP_WORD;
			standby_pkg::NOP_WORD:  next_state = standby_pkg::DONE;
			standby_pkg::DONE:      next_state = standby_pkg::DONE;   // Only reset re-arms.
			default:                next_state = standby_pkg::IDLE;
		endcase
	end

	// Word for the current state.
	always_comb begin
		word.raw = 16'h0000;
		word_valid = 1'b1;
		unique case (state)
			standby_pkg::DUMMY: begin
				word.raw = 16'hFFFF;
			end
			standby_pkg::SYNC1: begin
				word.raw = 16'hAA99;   // Sync word, high half.
			end
			standby_pkg::SYNC2: begin
				word.raw = 16'h5566;   // Sync word, low half.
			end
			standby_pkg::GEN1_HDR: begin
				word = type1_hdr(standby_pkg::WRITE, REG_GENERAL1, 5'd1);
			end
			standby_pkg::GEN1_DATA: begin
				word.raw = 16'h0000;   // Low address bits.
			end
			standby_pkg::GEN2_HDR: begin
				word = type1_hdr(standby_pkg::WRITE, REG_GENERAL2, 5'd1);
			end
			standby_pkg::GEN2_DATA: begin
				word.raw = rescue ? `STANDBY_RESCUE_ADDR : `STANDBY_REGULAR_ADDR;
			end
			standby_pkg::CMD_HDR: begin
				word = type1_hdr(standby_pkg::WRITE, REG_CMD, 5'd1);
			end
			standby_pkg::IPROG: begin
				word.raw = CMD_IPROG;
			end
			standby_pkg::NOP_WORD: begin
				word = type1_hdr(standby_pkg::NOP, 6'h00, 5'd0);
			end
			default: begin
				word_valid = 1'b0;   // Idle and done emit nothing.
			end
		endcase
	end

	assign seq_done = (state == standby_pkg::DONE);

endmodule

// File: hdl/button_sync.sv
// Multi-stage synchronizer bringing one asynchronous button into the clock domain.
`include "standby_macros.svh"

module button_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic async_in,
	output logic sync_out
);

	localparam int STAGES = `STANDBY_SYNC_STAGES;

	logic [STAGES-1:0] chain;

	// First stage may go metastable, the rest give it time to settle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			chain <= '0;
		end else begin
			chain <= {chain[STAGES-2:0], async_in};
		end
	end

	assign sync_out = chain[STAGES-1];   // Oldest sample.

endmodule

// File: hdl/standby_pkg.sv
// Port-word union, type-1 header struct, opcode enum and sequencer state enum.
package standby_pkg;

	// Opcode field of a type-1 packet header.
	typedef enum logic [1:0] {
		NOP   = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} icap_op_e;

	// Type-1 packet header, MSB first as it goes to the port.
	typedef struct packed {
		logic [2:0] pkt_type;   // 3'b001 for type 1.
		icap_op_e   opcode;
		logic [5:0] reg_addr;   // Configuration register.
		logic [4:0] word_cnt;   // Data words that follow.
	} type1_hdr_s;

	// A port word is either a packet header or plain data.
	typedef union packed {
		logic [15:0] raw;
		type1_hdr_s  hdr;
	} icap_word_u;

	// One state per emitted word, plus idle and done.
	typedef enum logic [3:0] {
		IDLE      = 4'd0,
		DUMMY     = 4'd1,
		SYNC1     = 4'd2,
		SYNC2     = 4'd3,
		GEN1_HDR  = 4'd4,
		GEN1_DATA = 4'd5,
		GEN2_HDR  = 4'd6,
		GEN2_DATA = 4'd7,
		CMD_HDR   = 4'd8,
		IPROG     = 4'd9,
		NOP_WORD  = 4'd10,
		DONE      = 4'd11
	} seq_state_e;

endpackage

// File: hdl/standby_macros.svh
// Sync depth and boot address macros for the standby reconfiguration controller.
`ifndef STANDBY_MACROS_SVH
`define STANDBY_MACROS_SVH

// Flip-flops in each button synchronizer chain.
`define STANDBY_SYNC_STAGES 2

// Multiboot address word for the rescue bitstream.
// Selected when the rescue button is held while idle.
`define STANDBY_RESCUE_ADDR 16'h0005

// Multiboot address word for the regular bitstream.
`define STANDBY_REGULAR_ADDR 16'h0037

`endif
